/* rtl/capture_defs.svh */
`ifndef CAPTURE_DEFS_SVH
`define CAPTURE_DEFS_SVH

// adc sample and packed word geometry
`define SAMPLE_W          12
`define WORD_W            36
`define SAMPLES_PER_WORD  3

// buffer depths, powers of two so the pointers wrap on their own
`define SAMPLE_DEPTH      64
`define WORD_DEPTH        256

// presample and sample counters
`define COUNT_W           32

// skip count of the decimator, same range as the capture hardware
`define DOWNSAMPLE_W      13

`endif

/* rtl/capture_pkg.sv */
`default_nettype none

`include "capture_defs.svh"

package capture_pkg;

    typedef logic [`SAMPLE_W-1:0] sample_t;  // one adc sample
    typedef logic [`WORD_W-1:0]   word_t;    // three samples, first one on top
    typedef logic [`COUNT_W-1:0]  count_t;

    typedef enum logic [2:0] {
        cap_idle,
        cap_presamp_filling,
        cap_presamp_full,     // window full, drain one per write
        cap_triggered,
        cap_done
    } capture_state_e;

    // controller to sample buffer
    typedef struct packed {
        logic    wr;
        sample_t data;
    } sample_wr_s;

    // packer to word buffer
    typedef struct packed {
        logic  wr;
        word_t data;
    } word_wr_s;

endpackage

`default_nettype wire

/* rtl/sample_decimator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

// keeps one sample out of every downsample_i+1
// not a real decimation filter, the other samples are just skipped
module sample_decimator (
    input  wire                     adc_sampleclk,
    input  wire                     reset,
    input  wire                     restart_i,
    input  wire [`DOWNSAMPLE_W-1:0] downsample_i,
    output logic                    keep_o
);

    logic [`DOWNSAMPLE_W-1:0] skip_cnt;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || restart_i) begin
            skip_cnt <= '0;
            keep_o   <= 1'b0;
        end else begin
            if (skip_cnt == downsample_i) begin  // top of count
                skip_cnt <= '0;
                keep_o   <= 1'b1;
            end else begin
                skip_cnt <= skip_cnt + 1'b1;
                keep_o   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/capture_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl
    import capture_pkg::*;
(
    input  wire         adc_sampleclk,
    input  wire         reset,
    input  wire         arm_i,
    input  wire         capture_go_i,
    input  wire         write_mask_i,
    input  wire         keep_i,
    input  wire sample_t adc_data_i,
    input  wire count_t presample_i,
    input  wire count_t max_samples_i,
    input  wire         sb_empty_i,      // nothing to forward
    input  wire         sb_full_i,
    output logic        arm_start_o,
    output sample_wr_s  sb_wr_o,
    output logic        sb_rd_o,
    output logic        forward_o,
    output logic        capture_stop_o
);

    capture_state_e state_q;
    logic           arm_q;
    logic           arm_edge;
    logic           writing;
    logic           sb_wr;
    logic           accepted;        // write that really lands in the buffer
    logic           drain;
    logic           quota_met;
    count_t         kept_cnt;        // samples kept for the output so far
    logic [1:0]     wr_mod3;

    assign arm_edge = arm_i & ~arm_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_q       <= 1'b0;
            arm_start_o <= 1'b0;
        end else begin
            arm_q       <= arm_i;
            arm_start_o <= arm_edge;  // one cycle clear pulse for the pipeline
        end
    end

    // length reached and the last word is complete
    assign quota_met = (kept_cnt >= max_samples_i) && (wr_mod3 == 2'd0);

    always_comb begin
        case (state_q)
            cap_presamp_filling: writing = (presample_i != '0);
            cap_presamp_full:    writing = 1'b1;
            cap_triggered:       writing = ~quota_met;  // also covers the padding
            default:             writing = 1'b0;
        endcase
    end

    // a write into a full buffer is refused there and flagged as overflow
    assign sb_wr    = keep_i & write_mask_i & writing;
    assign sb_wr_o  = '{wr: sb_wr, data: adc_data_i};
    assign accepted = sb_wr & ~sb_full_i;

    assign drain     = accepted & (state_q == cap_presamp_full);
    assign forward_o = ((state_q == cap_triggered) || (state_q == cap_done)) & ~sb_empty_i;
    assign sb_rd_o   = drain | forward_o;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_q        <= cap_idle;
            kept_cnt       <= '0;
            wr_mod3        <= 2'd0;
            capture_stop_o <= 1'b0;
        end else if (arm_start_o) begin
            state_q        <= cap_presamp_filling;
            kept_cnt       <= '0;
            wr_mod3        <= 2'd0;
            capture_stop_o <= 1'b0;
        end else begin
            // the window stays the same size while draining
            if (accepted && (state_q != cap_presamp_full)) begin
                kept_cnt <= kept_cnt + 1'b1;
                wr_mod3  <= (wr_mod3 == 2'd2) ? 2'd0 : wr_mod3 + 2'd1;
            end

            case (state_q)
                cap_presamp_filling: begin
                    if (capture_go_i)
                        state_q <= cap_triggered;  // early trigger, short window
                    else if (accepted && (kept_cnt == presample_i - 1'b1))
                        state_q <= cap_presamp_full;
                end
                cap_presamp_full: begin
                    if (capture_go_i)
                        state_q <= cap_triggered;
                end
                cap_triggered: begin
                    if (quota_met)
                        state_q <= cap_done;
                end
                cap_done: begin
                    // held here until the next arm edge
                    if (sb_empty_i)
                        capture_stop_o <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// first-word-fall-through store, DEPTH must be a power of two
module sample_buffer #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 64
) (
    input  wire              adc_sampleclk,
    input  wire              reset,
    input  wire              clear_i,
    input  wire              wr_i,
    input  wire [WIDTH-1:0]  din_i,
    input  wire              rd_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_ok;
    logic             rd_ok;

    assign empty_o = (count == '0);
    assign full_o  = (count == (PTR_W + 1)'(DEPTH));
    assign wr_ok   = wr_i & ~full_o;
    assign rd_ok   = rd_i & ~empty_o;
    assign dout_o  = mem[rd_ptr];  // head of queue, valid when not empty

    always_ff @(posedge adc_sampleclk) begin
        if (wr_ok)
            mem[wr_ptr] <= din_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overflow_o  <= wr_i & full_o;   // data lost
            underflow_o <= rd_i & empty_o;
        end
    end

endmodule

`default_nettype wire

/* rtl/sample_packer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module sample_packer
    import capture_pkg::*;
(
    input  wire          adc_sampleclk,
    input  wire          reset,
    input  wire          clear_i,
    input  wire          forward_i,
    input  wire sample_t sample_i,
    output word_wr_s     word_wr_o
);

    word_t      shift_q;
    logic [1:0] fill_cnt;  // samples already in the current word
    logic       wr_q;

    // oldest sample shifts up, so after three it sits in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (forward_i)
            shift_q <= {shift_q[`WORD_W-`SAMPLE_W-1:0], sample_i};
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            fill_cnt <= 2'd0;
            wr_q     <= 1'b0;
        end else begin
            wr_q <= 1'b0;
            if (forward_i) begin
                if (fill_cnt == 2'(`SAMPLES_PER_WORD - 1)) begin
                    fill_cnt <= 2'd0;
                    wr_q     <= 1'b1;  // word complete next cycle
                end else begin
                    fill_cnt <= fill_cnt + 2'd1;
                end
            end
        end
    end

    assign word_wr_o = '{wr: wr_q, data: shift_q};

endmodule

`default_nettype wire

/* rtl/byte_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_serializer
    import capture_pkg::*;
(
    input  wire        adc_sampleclk,
    input  wire        reset,
    input  wire        clear_i,
    input  wire        low_res_i,
    input  wire        read_en_i,
    input  wire word_t word_i,
    input  wire        word_empty_i,
    output logic       word_rd_o,
    output logic [7:0] read_data_o,
    output logic       read_empty_o
);

    logic [3:0] byte_idx;
    logic [3:0] nibble_q;     // low bits of sample 3, sent in byte 4
    logic       underflow_q;
    logic       last_byte;
    logic       word_done;

    // low res: 3 bytes per word; high res: 9 bytes per two words
    assign last_byte = low_res_i ? (byte_idx == 4'd2) : (byte_idx == 4'd8);
    assign word_done = last_byte | (~low_res_i & (byte_idx == 4'd3));

    // a read on empty is passed on so the buffer flags the underflow
    assign word_rd_o    = read_en_i & (word_done | word_empty_i);
    assign read_empty_o = word_empty_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            byte_idx    <= 4'd0;
            underflow_q <= 1'b0;
        end else if (read_en_i) begin
            if (word_empty_i)
                underflow_q <= 1'b1;  // index stays put, no data
            else if (last_byte)
                byte_idx <= 4'd0;
            else
                byte_idx <= byte_idx + 4'd1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (read_en_i && !word_empty_i && !low_res_i && (byte_idx == 4'd3))
            nibble_q <= word_i[3:0];
    end

    always_comb begin
        read_data_o = 8'h00;
        if (!underflow_q && !word_empty_i) begin
            if (low_res_i) begin
                case (byte_idx)
                    4'd0:    read_data_o = word_i[35:28];  // top 8 of each sample
                    4'd1:    read_data_o = word_i[23:16];
                    4'd2:    read_data_o = word_i[11:4];
                    default: read_data_o = 8'h00;
                endcase
            end else begin
                case (byte_idx)
                    4'd0:    read_data_o = word_i[35:28];
                    4'd1:    read_data_o = word_i[27:20];
                    4'd2:    read_data_o = word_i[19:12];
                    4'd3:    read_data_o = word_i[11:4];
                    4'd4:    read_data_o = {nibble_q, word_i[35:32]};  // spans both words
                    4'd5:    read_data_o = word_i[31:24];
                    4'd6:    read_data_o = word_i[23:16];
                    4'd7:    read_data_o = word_i[15:8];
                    4'd8:    read_data_o = word_i[7:0];
                    default: read_data_o = 8'h00;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/adc_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module adc_capture_top
    import capture_pkg::*;
(
    input  wire                     adc_sampleclk,
    input  wire                     reset,
    input  wire sample_t            adc_data_i,
    input  wire                     adc_write_mask_i,
    input  wire                     arm_i,
    input  wire                     capture_go_i,
    input  wire count_t             presample_i,
    input  wire count_t             max_samples_i,
    input  wire [`DOWNSAMPLE_W-1:0] downsample_i,
    input  wire                     low_res_i,
    input  wire                     read_en_i,
    output logic                    capture_stop_o,
    output logic [7:0]              read_data_o,
    output logic                    read_empty_o,
    output logic                    error_flag_o
);

    logic       arm_start;
    logic       keep;
    logic       forward;
    sample_wr_s sb_wr;
    logic       sb_rd;
    sample_t    sb_dout;
    logic       sb_empty;
    logic       sb_full;
    logic       sb_ovf;
    logic       sb_unf;
    logic       sample_hold;   // no sample may move on this cycle
    word_wr_s   wb_wr;
    logic       wb_rd;
    word_t      wb_dout;
    logic       wb_empty;
    logic       wb_full;
    logic       wb_ovf;
    logic       wb_unf;

    // a full word buffer stalls forwarding, the sample buffer absorbs the rest
    assign sample_hold = sb_empty | wb_full;

    sample_decimator i_sample_decimator (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .restart_i     (arm_start),
        .downsample_i  (downsample_i),
        .keep_o        (keep)
    );

    capture_ctrl i_capture_ctrl (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .write_mask_i   (adc_write_mask_i),
        .keep_i         (keep),
        .adc_data_i     (adc_data_i),
        .presample_i    (presample_i),
        .max_samples_i  (max_samples_i),
        .sb_empty_i     (sample_hold),
        .sb_full_i      (sb_full),
        .arm_start_o    (arm_start),
        .sb_wr_o        (sb_wr),
        .sb_rd_o        (sb_rd),
        .forward_o      (forward),
        .capture_stop_o (capture_stop_o)
    );

    sample_buffer #(
        .WIDTH (`SAMPLE_W),
        .DEPTH (`SAMPLE_DEPTH)
    ) i_sample_buffer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_start),
        .wr_i          (sb_wr.wr),
        .din_i         (sb_wr.data),
        .rd_i          (sb_rd),
        .dout_o        (sb_dout),
        .empty_o       (sb_empty),
        .full_o        (sb_full),
        .overflow_o    (sb_ovf),
        .underflow_o   (sb_unf)
    );

    sample_packer i_sample_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_start),
        .forward_i     (forward),
        .sample_i      (sb_dout),
        .word_wr_o     (wb_wr)
    );

    sample_buffer #(
        .WIDTH (`WORD_W),
        .DEPTH (`WORD_DEPTH)
    ) i_word_buffer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_start),
        .wr_i          (wb_wr.wr),
        .din_i         (wb_wr.data),
        .rd_i          (wb_rd),
        .dout_o        (wb_dout),
        .empty_o       (wb_empty),
        .full_o        (wb_full),
        .overflow_o    (wb_ovf),
        .underflow_o   (wb_unf)
    );

    byte_serializer i_byte_serializer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_start),
        .low_res_i     (low_res_i),
        .read_en_i     (read_en_i),
        .word_i        (wb_dout),
        .word_empty_i  (wb_empty),
        .word_rd_o     (wb_rd),
        .read_data_o   (read_data_o),
        .read_empty_o  (read_empty_o)
    );

    // sticky until the next arm
    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_start)
            error_flag_o <= 1'b0;
        else if (sb_ovf || sb_unf || wb_ovf || wb_unf)
            error_flag_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/adc_capture_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the top level ports, bound into adc_capture_top
module adc_capture_chk (
    input wire adc_sampleclk,
    input wire reset,
    input wire arm_i,
    input wire read_en_i,
    input wire read_empty_o,
    input wire capture_stop_o,
    input wire error_flag_o
);

    // buffers come out of reset empty
    empty_after_reset: assert property (
        @(posedge adc_sampleclk) reset |=> read_empty_o
    ) else $error("read_empty_o low after reset");

    stop_low_after_reset: assert property (
        @(posedge adc_sampleclk) reset |=> !capture_stop_o
    ) else $error("capture_stop_o high after reset");

    // arm edge, then arm_start, then the stop level clears
    stop_falls_on_arm: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        $fell(capture_stop_o) |-> ($past(arm_i, 2) && !$past(arm_i, 3))
    ) else $error("capture_stop_o fell without an arm edge");

    // a read on an empty buffer never goes unnoticed
    no_silent_empty_read: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (read_en_i && read_empty_o && !error_flag_o) |=> ##1 error_flag_o
    ) else $error("byte read on empty buffer without error flag");

endmodule

bind adc_capture_top adc_capture_chk i_adc_capture_chk (.*);

`default_nettype wire

/* verification/adc_capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "capture_defs.svh"

module adc_capture_tb
    import capture_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int TEST_CYCLES = 1200;  // worst case per test, setup to readout
    localparam int NUM_TESTS   = 5;
    localparam int WATCHDOG_NS = (16 + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD * 2;

    logic                     adc_sampleclk;
    logic                     reset;
    sample_t                  adc_data_i;
    logic                     adc_write_mask_i;
    logic                     arm_i;
    logic                     capture_go_i;
    count_t                   presample_i;
    count_t                   max_samples_i;
    logic [`DOWNSAMPLE_W-1:0] downsample_i;
    logic                     low_res_i;
    logic                     read_en_i;
    logic                     capture_stop_o;
    logic [7:0]               read_data_o;
    logic                     read_empty_o;
    logic                     error_flag_o;

    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    sample_t    trig_val;

    adc_capture_top i_adc_capture_top (.*);

    initial begin
        adc_sampleclk = 1'b0;
        forever #(CLK_PERIOD / 2) adc_sampleclk = ~adc_sampleclk;
    end

    // free running ramp on the adc input
    always @(posedge adc_sampleclk) adc_data_i <= adc_data_i + 1'b1;

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out, the DUT did not finish the tests in time");
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // bytes of a ramp capture: 12 bit samples, MSB first, or top 8 bits each
    function automatic void expected_bytes(input sample_t start, input int step,
                                           input int n, input bit low_res);
        sample_t smp;
        int      acc;
        int      nbits;
        exp_q.delete();
        acc   = 0;
        nbits = 0;
        for (int i = 0; i < n; i++) begin
            smp = sample_t'(int'(start) + i * step);
            if (low_res) begin
                exp_q.push_back(smp[11:4]);
            end else begin
                acc   = (acc << 12) | int'(smp);
                nbits = nbits + 12;
                while (nbits >= 8) begin
                    exp_q.push_back(8'((acc >> (nbits - 8)) & 8'hff));
                    nbits = nbits - 8;
                    acc   = acc & ((1 << nbits) - 1);
                end
            end
        end
    endfunction

    function automatic int padded(input int n);
        return ((n + 2) / 3) * 3;
    endfunction

    task automatic run_capture(input int ds, input int pre, input int max_n,
                               input bit low_res);
        int waited;
        @(posedge adc_sampleclk);
        downsample_i  <= `DOWNSAMPLE_W'(ds);
        presample_i   <= count_t'(pre);
        max_samples_i <= count_t'(max_n);
        low_res_i     <= low_res;
        arm_i         <= 1'b0;
        capture_go_i  <= 1'b0;
        @(posedge adc_sampleclk);
        arm_i <= 1'b1;
        repeat ((pre + 2) * (ds + 1) + 8) @(posedge adc_sampleclk);  // fill window
        capture_go_i <= 1'b1;
        trig_val     = adc_data_i;
        @(posedge adc_sampleclk);
        capture_go_i <= 1'b0;
        waited = 0;
        while (!capture_stop_o && waited < 2000) begin
            @(posedge adc_sampleclk);
            waited++;
        end
        if (!capture_stop_o) begin
            $display("capture_stop_o never rose after the trigger");
            stop_with_failure();
        end
        repeat (4) @(posedge adc_sampleclk);  // last word lands in the buffer
    endtask

    task automatic read_bytes(input int count);
        got_q.delete();
        for (int i = 0; i < count; i++) begin
            @(posedge adc_sampleclk);
            if (read_empty_o) begin
                $display("word buffer ran empty after %0d of %0d bytes", i, count);
                stop_with_failure();
            end
            got_q.push_back(read_data_o);
            read_en_i <= 1'b1;
            @(posedge adc_sampleclk);
            read_en_i <= 1'b0;
        end
        repeat (2) @(posedge adc_sampleclk);
        check_value("read_empty_o", read_empty_o, 1);
    endtask

    // ramp start that fits best, no more than pre steps before the trigger
    task automatic compare_capture(input int step, input int n, input bit low_res,
                                   input int pre);
        int lo;
        int hi;
        int best_len;
        int best_d;
        int len;
        lo       = -pre * step;
        hi       = 2 * step + 8;
        best_len = -1;
        best_d   = lo;
        for (int d = lo; d <= hi; d++) begin
            expected_bytes(sample_t'(int'(trig_val) + d), step, n, low_res);
            len = 0;
            while (len < exp_q.size() && len < got_q.size() && got_q[len] == exp_q[len])
                len++;
            if (len > best_len) begin
                best_len = len;
                best_d   = d;
            end
        end
        expected_bytes(sample_t'(int'(trig_val) + best_d), step, n, low_res);
        foreach (exp_q[i])
            check_value("read_data_o", got_q[i], exp_q[i]);
    endtask

    task automatic capture_and_check(input int ds, input int pre, input int max_n,
                                     input bit low_res);
        int n;
        n = padded(max_n);
        run_capture(ds, pre, max_n, low_res);
        read_bytes(low_res ? n : (n * 3) / 2);
        compare_capture(ds + 1, n, low_res, pre);
    endtask

    initial begin
        int ds;
        int pre;
        void'($urandom(32'h132d8836));
        reset            = 1'b1;
        adc_data_i       = '0;
        adc_write_mask_i = 1'b1;
        arm_i            = 1'b0;
        capture_go_i     = 1'b0;
        presample_i      = '0;
        max_samples_i    = '0;
        downsample_i     = '0;
        low_res_i        = 1'b1;
        read_en_i        = 1'b0;
        repeat (16) @(posedge adc_sampleclk);
        reset <= 1'b0;
        @(posedge adc_sampleclk);
        check_value("read_empty_o", read_empty_o, 1);
        check_value("capture_stop_o", capture_stop_o, 0);
        check_value("error_flag_o", error_flag_o, 0);

        capture_and_check(0, 0, 20, 1'b1);          // consecutive ramp, low res
        ds = 1 + ($urandom % 15);
        capture_and_check(ds, 0, 16, 1'b1);         // random decimation
        capture_and_check(2, 0, 29, 1'b0);          // high res, padded to 30
        ds  = $urandom % 4;
        pre = 3 + ($urandom % 18);
        capture_and_check(ds, pre, 24, 1'b0);       // presample window

        // read past the end, then re-arm
        @(posedge adc_sampleclk);
        read_en_i <= 1'b1;
        @(posedge adc_sampleclk);
        read_en_i <= 1'b0;
        repeat (3) @(posedge adc_sampleclk);
        check_value("read_data_o", read_data_o, 0);
        check_value("error_flag_o", error_flag_o, 1);
        arm_i <= 1'b0;
        @(posedge adc_sampleclk);
        arm_i <= 1'b1;
        repeat (4) @(posedge adc_sampleclk);
        check_value("error_flag_o", error_flag_o, 0);
        check_value("capture_stop_o", capture_stop_o, 0);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/capture_pkg.sv
rtl/sample_decimator.sv
rtl/capture_ctrl.sv
rtl/sample_buffer.sv
rtl/sample_packer.sv
rtl/byte_serializer.sv
rtl/adc_capture_top.sv
verification/adc_capture_chk.sv
verification/adc_capture_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module adc_capture_tb \
		-f sim.f -o adc_capture_sim
	./obj_dir/adc_capture_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
